//--- include/rvDecode_defs.svh
// width macros for the instruction word, its fields and the control word encodings
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// instruction word and the fixed fields of the base encoding
`define INSTR_W   32  // one uncompressed instruction
`define OPCODE_W  7   // bits 6:0
`define FUNCT3_W  3   // bits 14:12
`define FUNCT7_W  7   // bits 31:25

// control word fields seen by the datapath
`define ALUOP_W   5   // word bit, alt bit, funct3
`define MEMOP_W   3   // access size and sign
`define BRANCH_W  3   // jump or compare kind

`endif

//--- design/rvIsaPkg.sv
// ISA package: major opcodes, instruction field struct and funct7 markers
`default_nettype none

`include "rvDecode_defs.svh"

package rvIsaPkg;

  // instruction split along the R-type field boundaries
  typedef struct packed {
    logic [`FUNCT7_W-1:0] funct7;  // bits 31:25, bit 30 picks sub/sra
    logic [4:0]           rs2;     // bits 24:20
    logic [4:0]           rs1;     // bits 19:15
    logic [`FUNCT3_W-1:0] funct3;  // bits 14:12
    logic [4:0]           rd;      // bits 11:7
    logic [`OPCODE_W-1:0] opcode;  // bits 6:0
  } instrFields_t;

  // upper immediates
  localparam logic [`OPCODE_W-1:0] lui     = 7'b0110111;
  localparam logic [`OPCODE_W-1:0] auipc   = 7'b0010111;

  // jumps and conditional branches
  localparam logic [`OPCODE_W-1:0] jal     = 7'b1101111;
  localparam logic [`OPCODE_W-1:0] jalr    = 7'b1100111;
  localparam logic [`OPCODE_W-1:0] branch  = 7'b1100011;  // beq..bgeu

  // memory access
  localparam logic [`OPCODE_W-1:0] load    = 7'b0000011;  // lb..lwu, ld
  localparam logic [`OPCODE_W-1:0] store   = 7'b0100011;  // sb..sd

  // integer compute, 64-bit
  localparam logic [`OPCODE_W-1:0] opImm   = 7'b0010011;  // addi, shifts by imm
  localparam logic [`OPCODE_W-1:0] op      = 7'b0110011;  // reg-reg and M ext

  // integer compute, 32-bit word forms
  localparam logic [`OPCODE_W-1:0] opImm32 = 7'b0011011;  // addiw, slliw, srliw, sraiw
  localparam logic [`OPCODE_W-1:0] op32    = 7'b0111011;  // addw..sraw, mulw..remuw

  // funct7 markers in the reg-reg groups
  localparam logic [`FUNCT7_W-1:0] mulDivFunct7 = 7'b0000001;  // M extension
  localparam logic [`FUNCT7_W-1:0] altFunct7    = 7'b0100000;  // sub, sra

endpackage

`default_nettype wire

//--- design/ctrlPkg.sv
// control package: control word struct, source selects and the ALU, mul, imm, branch, mem enums
`default_nettype none

`include "rvDecode_defs.svh"

package ctrlPkg;

  // {word, alt, funct3} for base ops, fixed codes for M ext
  typedef enum logic [`ALUOP_W-1:0] {
    aluAdd       = 5'b00000,
    aluSll       = 5'b00001,
    aluSlt       = 5'b00010,  // also signed branch compare
    aluSltu      = 5'b00011,  // also unsigned branch compare
    aluXor       = 5'b00100,
    aluSrl       = 5'b00101,
    aluOr        = 5'b00110,
    aluAnd       = 5'b00111,
    aluSub       = 5'b01000,
    aluMulFamily = 5'b01001,  // mul, mulh*, half picked by mulOp
    aluDivu      = 5'b01010,
    aluDiv       = 5'b01011,
    aluRemu      = 5'b01100,
    aluSra       = 5'b01101,
    aluRem       = 5'b01110,
    aluPassImm   = 5'b01111,  // lui
    aluAddw      = 5'b10000,
    aluSllw      = 5'b10001,
    aluSrlw      = 5'b10101,
    aluSubw      = 5'b11000,
    aluMulw      = 5'b11001,
    aluDivuw     = 5'b11010,
    aluDivw      = 5'b11011,
    aluRemuw     = 5'b11100,
    aluSraw      = 5'b11101,
    aluRemw      = 5'b11110
  } aluOp_e;

  typedef enum logic [1:0] {
    mulLow                = 2'b00,
    mulHighUnsigned       = 2'b01,
    mulHighSignedUnsigned = 2'b10,
    mulHighSigned         = 2'b11
  } mulOp_e;

  typedef enum logic [2:0] {immI, immU, immS, immB, immJ, immR} immFmt_e;

  typedef enum logic [`BRANCH_W-1:0] {
    brNone = 3'b000,
    brJal  = 3'b001,
    brJalr = 3'b010,
    brEq   = 3'b100,
    brNe   = 3'b101,
    brLt   = 3'b110,  // signed or unsigned per aluOp
    brGe   = 3'b111
  } branch_e;

  typedef enum logic [`MEMOP_W-1:0] {
    memWord   = 3'b000,
    memByte   = 3'b001,
    memHalf   = 3'b010,
    memDouble = 3'b011,
    memWordU  = 3'b100,
    memByteU  = 3'b101,
    memHalfU  = 3'b110
  } memOp_e;

  localparam logic       srcAPc   = 1'b0;
  localparam logic       srcARs1  = 1'b1;
  localparam logic [1:0] srcBRs2  = 2'd0;
  localparam logic [1:0] srcBImm  = 2'd1;
  localparam logic [1:0] srcBFour = 2'd2;  // link address pc+4

  typedef struct packed {
    logic       aluSrcA;   // 0 pc, 1 rs1
    logic [1:0] aluSrcB;   // 0 rs2, 1 imm, 2 four
    immFmt_e    immFmt;
    aluOp_e     aluOp;
    branch_e    branch;
    memOp_e     memOp;
    mulOp_e     mulOp;
    logic       memToReg;  // load result to rd
    logic       regWen;
    logic       memWen;
  } ctrlWord_t;

  // nothing written, no jump, no memory traffic
  localparam ctrlWord_t ctrlIdle = '{aluSrcA: srcARs1, aluSrcB: srcBRs2, immFmt: immI,
                                     aluOp: aluAdd, branch: brNone, memOp: memWord,
                                     mulOp: mulLow, memToReg: 1'b0, regWen: 1'b0,
                                     memWen: 1'b0};

endpackage

`default_nettype wire

//--- design/handshakeSlot.sv
// handshakeSlot: one-entry buffer between two four-phase req/ack ports, payload type parameter
`default_nettype none

module handshakeSlot #(
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire logic     inReq_i,    // upstream request
  input  wire payload_t inData_i,   // stable while inReq_i high
  output logic          inAck_o,
  output logic          outReq_o,   // downstream request
  output payload_t      outData_o,
  input  wire logic     outAck_i
);

  payload_t dataQ;      // the one held item
  logic     fullQ;      // entry occupied
  logic     inAckQ;     // upstream phase
  logic     outReqQ;    // downstream phase
  logic     takeIn;
  logic     freeEntry;

  assign takeIn    = inReq_i && !fullQ && !inAckQ;  // empty and previous ack already dropped
  assign freeEntry = outReqQ && outAck_i;           // receiver has it

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fullQ   <= 1'b0;
      inAckQ  <= 1'b0;
      outReqQ <= 1'b0;
    end else begin
      if (takeIn) begin
        fullQ  <= 1'b1;
        inAckQ <= 1'b1;  // phase 2 upstream
      end else if (freeEntry) begin
        fullQ <= 1'b0;
      end
      if (inAckQ && !inReq_i)
        inAckQ <= 1'b0;  // phase 4, sender let go
      // wait for the last ack to fall before a new request
      if (fullQ && !outReqQ && !outAck_i)
        outReqQ <= 1'b1;
      else if (freeEntry)
        outReqQ <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (takeIn)
      dataQ <= inData_i;  // held until the next accept
  end

  assign inAck_o   = inAckQ;
  assign outReq_o  = outReqQ;
  assign outData_o = dataQ;

endmodule

`default_nettype wire

//--- design/aluFuncDecode.sv
// aluFuncDecode: ALU op and mul op from opcode, funct3, funct7 and bit 30
`default_nettype none

`include "rvDecode_defs.svh"

module aluFuncDecode (
  input  wire rvIsaPkg::instrFields_t fields_i,
  output ctrlPkg::aluOp_e             aluOp_o,
  output ctrlPkg::mulOp_e             mulOp_o
);

  logic                 isRegReg;  // op or op32
  logic                 isWord;    // 32-bit word group
  logic                 isMulDiv;  // M extension
  logic                 altSel;    // sub or sra
  logic [`FUNCT3_W-1:0] baseF3;

  always_comb begin
    isRegReg = (fields_i.opcode == rvIsaPkg::op) || (fields_i.opcode == rvIsaPkg::op32);
    isWord   = (fields_i.opcode == rvIsaPkg::opImm32) || (fields_i.opcode == rvIsaPkg::op32);
    isMulDiv = isRegReg && (fields_i.funct7 == rvIsaPkg::mulDivFunct7);

    // word forms only know add, sll and right shifts
    if (isWord && (fields_i.funct3 != 3'b000) && (fields_i.funct3 != 3'b001))
      baseF3 = 3'b101;
    else
      baseF3 = fields_i.funct3;

    if (baseF3 == 3'b101)
      altSel = fields_i.funct7[5];  // bit 30, sra vs srl
    else if ((baseF3 == 3'b000) && isRegReg)
      altSel = (fields_i.funct7 == rvIsaPkg::altFunct7);  // sub, addi has no alt
    else
      altSel = 1'b0;
  end

  always_comb begin
    aluOp_o = ctrlPkg::aluAdd;  // address add for loads, stores, jumps, auipc
    mulOp_o = ctrlPkg::mulLow;
    case (fields_i.opcode)
      rvIsaPkg::op, rvIsaPkg::op32, rvIsaPkg::opImm, rvIsaPkg::opImm32: begin
        if (isMulDiv && isWord) begin
          case (fields_i.funct3)
            3'b100:  aluOp_o = ctrlPkg::aluDivw;
            3'b101:  aluOp_o = ctrlPkg::aluDivuw;
            3'b110:  aluOp_o = ctrlPkg::aluRemw;
            3'b111:  aluOp_o = ctrlPkg::aluRemuw;
            default: aluOp_o = ctrlPkg::aluMulw;  // undefined ones too
          endcase
        end else if (isMulDiv) begin
          case (fields_i.funct3)
            3'b000: aluOp_o = ctrlPkg::aluMulFamily;
            3'b001: begin
              aluOp_o = ctrlPkg::aluMulFamily;  // mulh
              mulOp_o = ctrlPkg::mulHighSigned;
            end
            3'b010: begin
              aluOp_o = ctrlPkg::aluMulFamily;  // mulhsu
              mulOp_o = ctrlPkg::mulHighSignedUnsigned;
            end
            3'b011: begin
              aluOp_o = ctrlPkg::aluMulFamily;  // mulhu
              mulOp_o = ctrlPkg::mulHighUnsigned;
            end
            3'b100:  aluOp_o = ctrlPkg::aluDiv;
            3'b101:  aluOp_o = ctrlPkg::aluDivu;
            3'b110:  aluOp_o = ctrlPkg::aluRem;
            default: aluOp_o = ctrlPkg::aluRemu;
          endcase
        end else begin
          aluOp_o = ctrlPkg::aluOp_e'({isWord, altSel, baseF3});
        end
      end
      rvIsaPkg::branch: aluOp_o = fields_i.funct3[1] ? ctrlPkg::aluSltu : ctrlPkg::aluSlt;
      rvIsaPkg::lui:    aluOp_o = ctrlPkg::aluPassImm;
      default:          aluOp_o = ctrlPkg::aluAdd;
    endcase
  end

endmodule

`default_nettype wire

//--- design/instrDecoder.sv
// instrDecoder: opcode classification into the full control word, ALU op merged from aluFuncDecode
`default_nettype none

module instrDecoder (
  input  wire rvIsaPkg::instrFields_t instr_i,
  output ctrlPkg::ctrlWord_t          ctrl_o
);

  ctrlPkg::aluOp_e aluOp;  // from the funct table
  ctrlPkg::mulOp_e mulOp;

  aluFuncDecode aluFuncDecode_inst (
    .fields_i (instr_i),
    .aluOp_o  (aluOp),
    .mulOp_o  (mulOp)
  );

  always_comb begin
    ctrl_o = ctrlPkg::ctrlIdle;  // unknown, system and fence opcodes stay here
    case (instr_i.opcode)
      rvIsaPkg::lui, rvIsaPkg::auipc: begin
        ctrl_o.aluSrcA = (instr_i.opcode == rvIsaPkg::auipc) ? ctrlPkg::srcAPc
                                                            : ctrlPkg::srcARs1;
        ctrl_o.aluSrcB = ctrlPkg::srcBImm;
        ctrl_o.immFmt  = ctrlPkg::immU;
        ctrl_o.aluOp   = aluOp;  // passImm for lui
        ctrl_o.regWen  = 1'b1;
      end
      rvIsaPkg::jal, rvIsaPkg::jalr: begin
        ctrl_o.aluSrcA = ctrlPkg::srcAPc;    // rd gets pc+4
        ctrl_o.aluSrcB = ctrlPkg::srcBFour;
        ctrl_o.aluOp   = aluOp;
        ctrl_o.regWen  = 1'b1;
        if (instr_i.opcode == rvIsaPkg::jal) begin
          ctrl_o.immFmt = ctrlPkg::immJ;
          ctrl_o.branch = ctrlPkg::brJal;
        end else begin
          ctrl_o.immFmt = ctrlPkg::immI;     // target from rs1 + imm
          ctrl_o.branch = ctrlPkg::brJalr;
        end
      end
      rvIsaPkg::branch: begin
        ctrl_o.immFmt = ctrlPkg::immB;
        ctrl_o.aluOp  = aluOp;               // slt or sltu compare
        case (instr_i.funct3)
          3'b000:         ctrl_o.branch = ctrlPkg::brEq;
          3'b001:         ctrl_o.branch = ctrlPkg::brNe;
          3'b100, 3'b110: ctrl_o.branch = ctrlPkg::brLt;
          3'b101, 3'b111: ctrl_o.branch = ctrlPkg::brGe;
          default:        ctrl_o = ctrlPkg::ctrlIdle;
        endcase
      end
      rvIsaPkg::load: begin
        ctrl_o.aluSrcB  = ctrlPkg::srcBImm;
        ctrl_o.aluOp    = aluOp;
        ctrl_o.memToReg = 1'b1;
        ctrl_o.regWen   = 1'b1;
        case (instr_i.funct3)
          3'b000:  ctrl_o.memOp = ctrlPkg::memByte;
          3'b001:  ctrl_o.memOp = ctrlPkg::memHalf;
          3'b010:  ctrl_o.memOp = ctrlPkg::memWord;
          3'b011:  ctrl_o.memOp = ctrlPkg::memDouble;
          3'b100:  ctrl_o.memOp = ctrlPkg::memByteU;
          3'b101:  ctrl_o.memOp = ctrlPkg::memHalfU;
          3'b110:  ctrl_o.memOp = ctrlPkg::memWordU;
          default: ctrl_o = ctrlPkg::ctrlIdle;  // no 128-bit load
        endcase
      end
      rvIsaPkg::store: begin
        ctrl_o.aluSrcB = ctrlPkg::srcBImm;
        ctrl_o.immFmt  = ctrlPkg::immS;
        ctrl_o.aluOp   = aluOp;
        ctrl_o.memWen  = 1'b1;
        case (instr_i.funct3)
          3'b000:  ctrl_o.memOp = ctrlPkg::memByte;
          3'b001:  ctrl_o.memOp = ctrlPkg::memHalf;
          3'b010:  ctrl_o.memOp = ctrlPkg::memWord;
          3'b011:  ctrl_o.memOp = ctrlPkg::memDouble;
          default: ctrl_o = ctrlPkg::ctrlIdle;
        endcase
      end
      rvIsaPkg::opImm, rvIsaPkg::opImm32: begin
        ctrl_o.aluSrcB = ctrlPkg::srcBImm;
        ctrl_o.aluOp   = aluOp;
        ctrl_o.regWen  = 1'b1;
      end
      rvIsaPkg::op, rvIsaPkg::op32: begin
        ctrl_o.immFmt = ctrlPkg::immR;     // rs2 operand, no immediate
        ctrl_o.aluOp  = aluOp;
        ctrl_o.mulOp  = mulOp;             // only non-low for mulh*
        ctrl_o.regWen = 1'b1;
      end
      default: ctrl_o = ctrlPkg::ctrlIdle;
    endcase
  end

endmodule

`default_nettype wire

//--- design/decodeTop.sv
// decodeTop: input slot for the instruction, decoder, output slot for the control word
`default_nettype none

`include "rvDecode_defs.svh"

module decodeTop (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                instrReq_i,
  input  wire logic [`INSTR_W-1:0] instr_i,
  output logic                     instrAck_o,
  output logic                     ctrlReq_o,
  output ctrlPkg::ctrlWord_t       ctrlWord_o,
  input  wire logic                ctrlAck_i
);

  logic                   instrValid;  // input slot downstream req
  logic                   instrTaken;  // output slot upstream ack
  rvIsaPkg::instrFields_t instrHeld;
  ctrlPkg::ctrlWord_t     ctrlNext;    // decoded, not yet captured

  handshakeSlot #(.payload_t(rvIsaPkg::instrFields_t)) instrSlot_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .inReq_i   (instrReq_i),
    .inData_i  (rvIsaPkg::instrFields_t'(instr_i)),
    .inAck_o   (instrAck_o),
    .outReq_o  (instrValid),
    .outData_o (instrHeld),
    .outAck_i  (instrTaken)
  );

  instrDecoder instrDecoder_inst (
    .instr_i (instrHeld),
    .ctrl_o  (ctrlNext)
  );

  handshakeSlot #(.payload_t(ctrlPkg::ctrlWord_t)) ctrlSlot_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .inReq_i   (instrValid),
    .inData_i  (ctrlNext),
    .inAck_o   (instrTaken),
    .outReq_o  (ctrlReq_o),
    .outData_o (ctrlWord_o),
    .outAck_i  (ctrlAck_i)
  );

endmodule

`default_nettype wire

//--- verif/decodeChecker.sv
// decodeChecker: reference decode function, in-order compare of control words, per-test report
`default_nettype none

`include "rvDecode_defs.svh"

module decodeChecker (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                instrAck_i,
  input  wire logic [`INSTR_W-1:0] instr_i,
  input  wire logic                ctrlReq_i,
  input  wire ctrlPkg::ctrlWord_t  ctrlWord_i,
  output int                       checked_o,
  output int                       errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // lb lh lw ld lbu lhu lwu, indexed by funct3
  localparam logic [2:0] memByF3 [8] = '{3'b001, 3'b010, 3'b000, 3'b011,
                                         3'b101, 3'b110, 3'b100, 3'b000};

  logic [`INSTR_W-1:0] pending[$];  // accepted, no control word yet
  logic                ackSeen;
  logic                reqSeen;

  // expected control word, fields in struct order
  function automatic logic [21:0] expectedCtrl(input logic [`INSTR_W-1:0] w);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       wordForm;
    logic       regReg;
    logic       alt;
    logic       srcA;
    logic [1:0] srcB;
    logic [2:0] imm;
    logic [4:0] alu;
    logic [2:0] br;
    logic [2:0] mem;
    logic [1:0] mul;
    logic [2:0] wen;  // memToReg, regWen, memWen
    opc      = w[6:0];
    f3       = w[14:12];
    wordForm = (opc == 7'b0011011) || (opc == 7'b0111011);
    regReg   = (opc == 7'b0110011) || (opc == 7'b0111011);
    if ((opc == 7'b1100011 && f3[2:1] == 2'b01) || (opc == 7'b0000011 && f3 == 3'b111)
        || (opc == 7'b0100011 && f3[2]))
      return 22'h20_0000;  // undefined funct3 gives the idle word
    srcA = 1'b1;
    srcB = 2'd0;
    imm  = 3'd0;
    alu  = 5'd0;
    br   = 3'd0;
    mem  = 3'd0;
    mul  = 2'd0;
    wen  = 3'b000;
    case (opc)
      7'b0110111, 7'b0010111: begin  // lui, auipc
        srcA = (opc == 7'b0110111);
        srcB = 2'd1;
        imm  = 3'd1;
        alu  = (opc == 7'b0110111) ? 5'b01111 : 5'b00000;
        wen  = 3'b010;
      end
      7'b1101111, 7'b1100111: begin  // jal, jalr
        srcA = 1'b0;
        srcB = 2'd2;                 // link value pc+4
        imm  = (opc == 7'b1101111) ? 3'd4 : 3'd0;
        br   = (opc == 7'b1101111) ? 3'b001 : 3'b010;
        wen  = 3'b010;
      end
      7'b1100011: begin
        imm = 3'd3;
        alu = (f3[2:1] == 2'b11) ? 5'b00011 : 5'b00010;  // bltu, bgeu compare unsigned
        br  = {1'b1, f3[2], f3[0]};
      end
      7'b0000011, 7'b0100011: begin
        srcB = 2'd1;
        imm  = (opc == 7'b0100011) ? 3'd2 : 3'd0;
        wen  = (opc == 7'b0100011) ? 3'b001 : 3'b110;
        mem  = memByF3[f3];
      end
      7'b0010011, 7'b0011011, 7'b0110011, 7'b0111011: begin
        srcB = regReg ? 2'd0 : 2'd1;
        imm  = regReg ? 3'd5 : 3'd0;
        wen  = 3'b010;
        alt  = (f3 == 3'b101) ? w[30] : (regReg && w[31:25] == 7'b0100000 && f3 == 3'b000);
        alu  = {wordForm, alt, f3};
        if (regReg && w[31:25] == 7'b0000001) begin
          case (f3)
            3'b000:  alu = 5'b01001;
            3'b001:  {alu, mul} = {5'b01001, 2'b11};  // mulh
            3'b010:  {alu, mul} = {5'b01001, 2'b10};  // mulhsu
            3'b011:  {alu, mul} = {5'b01001, 2'b01};  // mulhu
            3'b100:  alu = 5'b01011;
            3'b101:  alu = 5'b01010;
            3'b110:  alu = 5'b01110;
            default: alu = 5'b01100;
          endcase
          if (wordForm) begin
            alu[4] = 1'b1;
            mul    = 2'b00;
            if (!f3[2])
              alu = 5'b11001;  // mulw, undefined slots too
          end
        end
      end
      default: ;  // system, fence, unknown
    endcase
    return {srcA, srcB, imm, alu, br, mem, mul, wen};
  endfunction

  always @(posedge clk_i) begin
    logic [`INSTR_W-1:0] w;
    logic [21:0]         expected;
    logic [21:0]         actual;
    if (rst_i) begin
      ackSeen <= 1'b0;
      reqSeen <= 1'b0;
    end else begin
      ackSeen <= instrAck_i;
      reqSeen <= ctrlReq_i;
      if (instrAck_i && !ackSeen)
        pending.push_back(instr_i);  // held stable until ack drops
      if (ctrlReq_i && !reqSeen) begin
        if (pending.size() == 0) begin
          errors_o = errors_o + 1;
          $display("control word %06h came out with no instruction outstanding", ctrlWord_i);
        end else begin
          w        = pending.pop_front();
          expected = expectedCtrl(w);
          actual   = ctrlWord_i;
          if (actual !== expected) begin
            errors_o = errors_o + 1;
            $display("Fail test%0d instr %08h: expected %06h, actual %06h",
                     checked_o, w, expected, actual);
          end else begin
            $display("Pass test%0d instr %08h ctrl %06h", checked_o, w, actual);
          end
          checked_o = checked_o + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/decodeTb.sv
// decodeTb: clock, reset, producer and consumer handshakes, test list, watchdog
`default_nettype none

`include "rvDecode_defs.svh"

module decodeTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cyclesPerTest = 40;  // slow consumer with both slots full

  logic                clk;
  logic                rst;
  logic                instrReq;
  logic [`INSTR_W-1:0] instr;
  logic                instrAck;
  logic                ctrlReq;
  ctrlPkg::ctrlWord_t  ctrlWord;
  logic                ctrlAck;
  logic [`INSTR_W-1:0] tests[$];
  logic                listReady = 1'b0;
  int                  seed = 56730;
  int                  checked;
  int                  errors;
  int                  resetErrors = 0;

  decodeTop decodeTop_inst (
    .clk_i      (clk),
    .rst_i      (rst),
    .instrReq_i (instrReq),
    .instr_i    (instr),
    .instrAck_o (instrAck),
    .ctrlReq_o  (ctrlReq),
    .ctrlWord_o (ctrlWord),
    .ctrlAck_i  (ctrlAck)
  );

  decodeChecker decodeChecker_inst (
    .clk_i      (clk),
    .rst_i      (rst),
    .instrAck_i (instrAck),
    .instr_i    (instr),
    .ctrlReq_i  (ctrlReq),
    .ctrlWord_i (ctrlWord),
    .checked_o  (checked),
    .errors_o   (errors)
  );

  function automatic logic [`INSTR_W-1:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [6:0] opc);
    return {f7, 5'd3, 5'd2, f3, 5'd1, opc};  // rs2 x3, rs1 x2, rd x1
  endfunction

  function automatic logic knownOpcode(input logic [6:0] opc);
    return opc inside {rvIsaPkg::lui, rvIsaPkg::auipc, rvIsaPkg::jal, rvIsaPkg::jalr,
                       rvIsaPkg::branch, rvIsaPkg::load, rvIsaPkg::store, rvIsaPkg::opImm,
                       rvIsaPkg::op, rvIsaPkg::opImm32, rvIsaPkg::op32};
  endfunction

  task automatic buildTests();
    logic [`INSTR_W-1:0] w;
    for (int f = 0; f < 8; f++) begin
      tests.push_back(encode(7'h00, f[2:0], rvIsaPkg::op));
      tests.push_back(encode(7'h01, f[2:0], rvIsaPkg::op));    // M extension
      tests.push_back(encode(7'h01, f[2:0], rvIsaPkg::op32));  // word M, undefined slots too
      tests.push_back(encode(7'h00, f[2:0], rvIsaPkg::opImm));
      tests.push_back(encode(7'h2a, f[2:0], rvIsaPkg::load));
      tests.push_back(encode(7'h15, f[2:0], rvIsaPkg::store));
      tests.push_back(encode(7'h7f, f[2:0], rvIsaPkg::branch));
    end
    tests.push_back(encode(7'h20, 3'b000, rvIsaPkg::op));       // sub
    tests.push_back(encode(7'h20, 3'b101, rvIsaPkg::op));       // sra
    tests.push_back(encode(7'h21, 3'b101, rvIsaPkg::opImm));    // srai, shamt bit 5
    tests.push_back(encode(7'h20, 3'b000, rvIsaPkg::opImm));    // addi with imm bit 30
    tests.push_back(encode(7'h00, 3'b000, rvIsaPkg::op32));     // addw
    tests.push_back(encode(7'h20, 3'b000, rvIsaPkg::op32));     // subw
    tests.push_back(encode(7'h00, 3'b001, rvIsaPkg::op32));     // sllw
    tests.push_back(encode(7'h00, 3'b101, rvIsaPkg::op32));     // srlw
    tests.push_back(encode(7'h20, 3'b101, rvIsaPkg::op32));     // sraw
    tests.push_back(encode(7'h12, 3'b000, rvIsaPkg::opImm32));  // addiw
    tests.push_back(encode(7'h00, 3'b001, rvIsaPkg::opImm32));  // slliw
    tests.push_back(encode(7'h00, 3'b101, rvIsaPkg::opImm32));  // srliw
    tests.push_back(encode(7'h20, 3'b101, rvIsaPkg::opImm32));  // sraiw
    tests.push_back(encode(7'h5a, 3'b000, rvIsaPkg::lui));
    tests.push_back(encode(7'h33, 3'b110, rvIsaPkg::auipc));
    tests.push_back(encode(7'h7e, 3'b011, rvIsaPkg::jal));
    tests.push_back(encode(7'h01, 3'b000, rvIsaPkg::jalr));
    tests.push_back(32'h0000_0073);                       // ecall
    tests.push_back(32'h3020_0073);                       // mret
    tests.push_back(encode(7'h18, 3'b001, 7'b1110011));  // csrrw
    tests.push_back(encode(7'h00, 3'b000, 7'b0001111));  // fence
    tests.push_back(encode(7'h00, 3'b001, 7'b0001111));  // fence.i
    repeat (16) begin
      w = $random(seed);
      while (knownOpcode(w[6:0]))
        w = $random(seed);
      tests.push_back(w);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic sendInstr(input logic [`INSTR_W-1:0] w);
    instrReq <= 1'b1;
    instr    <= w;
    @(posedge clk);
    while (!instrAck)
      @(posedge clk);
    instrReq <= 1'b0;  // phase 3
    @(posedge clk);
    while (instrAck)
      @(posedge clk);
  endtask

  // consumer with random ack delay
  initial begin
    int delay;
    ctrlAck <= 1'b0;
    forever begin
      @(posedge clk);
      if (ctrlReq && !ctrlAck) begin
        delay = $unsigned($random(seed)) % 8;
        repeat (delay) @(posedge clk);
        ctrlAck <= 1'b1;
        @(posedge clk);
        while (ctrlReq)
          @(posedge clk);
        ctrlAck <= 1'b0;
      end
    end
  end

  initial begin
    rst      <= 1'b1;
    instrReq <= 1'b1;  // a request during reset must not be taken
    instr    <= '0;
    buildTests();
    listReady = 1'b1;
    repeat (4) @(posedge clk);
    rst      <= 1'b0;
    instrReq <= 1'b0;
    @(posedge clk);
    if (instrAck !== 1'b0 || ctrlReq !== 1'b0) begin
      resetErrors = resetErrors + 1;
      $display("instrAck or ctrlReq was not low after reset");
    end
    foreach (tests[i])
      sendInstr(tests[i]);
    wait (checked == tests.size());
    repeat (20) @(posedge clk);  // room for a duplicate word to show
    $display("Counts: %0d sent, %0d checked, %0d failed",
             tests.size(), checked, errors + resetErrors);
    if (errors == 0 && resetErrors == 0 && checked == tests.size())
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  initial begin
    wait (listReady);
    #((tests.size() + 8) * cyclesPerTest * 20);
    $display("Timeout after %0d of %0d control words", checked, tests.size());
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
design/rvIsaPkg.sv
design/ctrlPkg.sv
design/handshakeSlot.sv
design/aluFuncDecode.sv
design/instrDecoder.sv
design/decodeTop.sv
verif/decodeChecker.sv
verif/decodeTb.sv

//--- Makefile
SIM      ?= verilator
TOP      ?= decodeTb
FILELIST ?= verilog.f
FLAGS    ?= --binary --timing
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS     := Result: PASSED

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
